// ==== design/shooter_macros.svh ====
`ifndef SHOOTER_MACROS_SVH
`define SHOOTER_MACROS_SVH

// Playfield and start positions
`define SCREEN_X        640
`define SHIP_X0         320
`define SHIP_Y0         240
`define ALIEN_X0        600
`define ALIEN_X_MIN     32
`define ALIEN_Y_MIN     16
`define ALIEN_Y_MAX     464

// Motion rates
`define SHIP_STEP       5
`define MISSILE_TICK    64
`define ALIEN_TICK      2048

// Collision boxes
`define MISSILE_LEN     25
`define MISSILE_THICK   3
`define ALIEN_SIZE      32

// PS/2 set 2 make codes
`define KEY_W           8'h1D
`define KEY_A           8'h1C
`define KEY_S           8'h1B
`define KEY_D           8'h23
`define KEY_FIRE        8'h3A
`define KEY_BREAK       8'hF0

`define LFSR_SEED       16'hBEEF

// Wishbone word addresses
`define REG_CTRL        0
`define REG_SCANCODE    1
`define REG_SCORE       2
`define REG_SHIP_X      3
`define REG_SHIP_Y      4
`define REG_ALIEN_X     5
`define REG_ALIEN_Y     6
`define REG_MISSILE_X   7

`endif

// ==== design/shooter_pkg.sv ====
package shooter_pkg;

    // Screen point, x over 640 columns and y over 480 rows
    typedef struct packed {
        logic [9:0] x;
        logic [8:0] y;
    } pos_t;

    typedef struct packed {
        logic clk;
        logic dat;
    } ps2_lines_t;

    // Flags are single-cycle pulses, scancode is held
    typedef struct packed {
        logic       move_up;
        logic       move_down;
        logic       move_left;
        logic       move_right;
        logic       fire;
        logic [7:0] scancode;
    } key_event_t;

    typedef enum logic [1:0] {
        MENU = 2'b00,
        PLAY = 2'b01,
        WON  = 2'b11
    } game_state_e;

    typedef struct packed {
        logic       cyc;
        logic       stb;
        logic       we;
        logic [2:0] adr;
        logic [7:0] dat_w;
    } wb_req_t;

    typedef struct packed {
        logic       ack;
        logic [7:0] dat_r;
    } wb_rsp_t;

endpackage

// ==== design/bit_sync.sv ====
module bit_sync #(
    parameter type payload_t = logic
) (
    input  logic     clock,
    input  logic     reset,
    input  payload_t d,
    output payload_t q
);
    payload_t meta;

    // Two flops against metastability on asynchronous inputs
    always_ff @(posedge clock) begin
        if (reset) begin
            meta <= '0;
            q    <= '0;
        end else begin
            meta <= d;
            q    <= meta;
        end
    end
endmodule

// ==== design/ps2_receiver.sv ====
`include "shooter_macros.svh"

module ps2_receiver (
    input  logic                    clock,
    input  logic                    reset,
    input  shooter_pkg::ps2_lines_t ps2,
    output shooter_pkg::key_event_t key
);
    shooter_pkg::ps2_lines_t ps2_s;
    logic       clk_prev;
    logic       fall;
    logic       frame_done;
    logic [3:0] bit_cnt;
    logic [9:0] shift;
    logic [7:0] byte_in;
    logic       skip;

    bit_sync #(
        .payload_t (shooter_pkg::ps2_lines_t)
    ) u_sync (
        .clock (clock),
        .reset (reset),
        .d     (ps2),
        .q     (ps2_s)
    );

    // Keyboard drives data on the falling clock edge
    assign fall       = clk_prev & ~ps2_s.clk;
    assign frame_done = fall && (bit_cnt == 4'd10);
    // Start bit sits in shift[0], data follows LSB first
    assign byte_in    = shift[8:1];

    always_ff @(posedge clock) begin
        if (reset) begin
            clk_prev <= 1'b0;
            bit_cnt  <= '0;
        end else begin
            clk_prev <= ps2_s.clk;
            if (frame_done) begin
                bit_cnt <= '0;
            end else if (fall) begin
                bit_cnt <= bit_cnt + 4'd1;
            end
        end
    end

    always_ff @(posedge clock) begin
        if (fall) begin
            shift <= {ps2_s.dat, shift[9:1]};
        end
    end

    //============================================================
    // Key decode
    //============================================================
    always_ff @(posedge clock) begin
        if (reset) begin
            key  <= '0;
            skip <= 1'b0;
        end else begin
            key.move_up    <= 1'b0;
            key.move_down  <= 1'b0;
            key.move_left  <= 1'b0;
            key.move_right <= 1'b0;
            key.fire       <= 1'b0;
            if (frame_done) begin
                if (skip) begin
                    // Released key code, drop it
                    skip <= 1'b0;
                end else if (byte_in == `KEY_BREAK) begin
                    skip <= 1'b1;
                end else begin
                    key.scancode   <= byte_in;
                    key.move_up    <= (byte_in == `KEY_W);
                    key.move_down  <= (byte_in == `KEY_S);
                    key.move_left  <= (byte_in == `KEY_A);
                    key.move_right <= (byte_in == `KEY_D);
                    key.fire       <= (byte_in == `KEY_FIRE);
                end
            end
        end
    end
endmodule

// ==== design/player_ship.sv ====
`include "shooter_macros.svh"

module player_ship (
    input  logic                     clock,
    input  logic                     reset,
    input  shooter_pkg::game_state_e state,
    input  shooter_pkg::key_event_t  key,
    output shooter_pkg::pos_t        ship
);
    localparam logic [9:0] STEP_X = 10'(`SHIP_STEP);
    localparam logic [8:0] STEP_Y = 9'(`SHIP_STEP);

    // Position wraps at the register width, no clamp
    always_ff @(posedge clock) begin
        if (reset) begin
            ship.x <= 10'(`SHIP_X0);
            ship.y <= 9'(`SHIP_Y0);
        end else if (state == shooter_pkg::PLAY) begin
            if (key.move_left) begin
                ship.x <= ship.x - STEP_X;
            end else if (key.move_right) begin
                ship.x <= ship.x + STEP_X;
            end

            // Screen y grows downward
            if (key.move_up) begin
                ship.y <= ship.y - STEP_Y;
            end else if (key.move_down) begin
                ship.y <= ship.y + STEP_Y;
            end
        end
    end
endmodule

// ==== design/alien_ship.sv ====
`include "shooter_macros.svh"

module alien_ship (
    input  logic                     clock,
    input  logic                     reset,
    input  shooter_pkg::game_state_e state,
    input  logic                     hit,
    output shooter_pkg::pos_t        alien,
    output logic                     alive
);
    localparam int TICK_W = $clog2(`ALIEN_TICK);

    logic [15:0]       lfsr;
    logic              feedback;
    logic [8:0]        row;
    logic              play_q;
    logic              enter_play;
    logic [TICK_W-1:0] tick_cnt;
    logic              tick;

    // Fibonacci LFSR, taps 16 14 13 11
    assign feedback   = lfsr[15] ^ lfsr[13] ^ lfsr[12] ^ lfsr[10];
    assign enter_play = (state == shooter_pkg::PLAY) && !play_q;
    assign tick       = (tick_cnt == TICK_W'(`ALIEN_TICK - 1));

    always_comb begin
        if (lfsr[8:0] < 9'(`ALIEN_Y_MIN)) begin
            row = 9'(`ALIEN_Y_MIN);
        end else if (lfsr[8:0] > 9'(`ALIEN_Y_MAX)) begin
            row = 9'(`ALIEN_Y_MAX);
        end else begin
            row = lfsr[8:0];
        end
    end

    always_ff @(posedge clock) begin
        if (reset) begin
            lfsr     <= `LFSR_SEED;
            tick_cnt <= '0;
            play_q   <= 1'b0;
        end else begin
            lfsr     <= {lfsr[14:0], feedback};
            tick_cnt <= tick ? '0 : tick_cnt + 1'b1;
            play_q   <= (state == shooter_pkg::PLAY);
        end
    end

    always_ff @(posedge clock) begin
        if (reset) begin
            alien.x <= 10'(`ALIEN_X0);
            alien.y <= 9'((`ALIEN_Y_MIN + `ALIEN_Y_MAX) / 2);
            alive   <= 1'b1;
        end else begin
            if (hit) begin
                alive <= 1'b0;
            end
            if (enter_play) begin
                alien.y <= row;
            end else if ((state == shooter_pkg::PLAY) && alive && tick &&
                         (alien.x > 10'(`ALIEN_X_MIN))) begin
                alien.x <= alien.x - 10'd1;
            end
        end
    end
endmodule

// ==== design/missile_tracker.sv ====
`include "shooter_macros.svh"

module missile_tracker (
    input  logic                     clock,
    input  logic                     reset,
    input  shooter_pkg::game_state_e state,
    input  shooter_pkg::key_event_t  key,
    input  shooter_pkg::pos_t        ship,
    input  shooter_pkg::pos_t        alien,
    input  logic                     alive,
    output shooter_pkg::pos_t        shot,
    output logic                     active,
    output logic                     hit
);
    localparam int          TICK_W = $clog2(`MISSILE_TICK);
    localparam logic [10:0] HALF   = 11'(`ALIEN_SIZE / 2);
    localparam logic [10:0] LEN_M1 = 11'(`MISSILE_LEN - 1);
    localparam logic [10:0] THK_M1 = 11'(`MISSILE_THICK - 1);

    logic [TICK_W-1:0] tick_cnt;
    logic              tick;
    logic [10:0]       sx;
    logic [10:0]       sy;
    logic [10:0]       ax;
    logic [10:0]       ay;
    logic              overlap;

    assign tick = (tick_cnt == TICK_W'(`MISSILE_TICK - 1));

    // Box test, alien centred on its position, written without subtraction
    assign sx = 11'(shot.x);
    assign sy = 11'(shot.y);
    assign ax = 11'(alien.x);
    assign ay = 11'(alien.y);
    assign overlap = (sx <= ax + HALF - 11'd1) && (sx + LEN_M1 + HALF >= ax) &&
                     (sy <= ay + HALF - 11'd1) && (sy + THK_M1 + HALF >= ay);

    always_ff @(posedge clock) begin
        if (reset) begin
            tick_cnt <= '0;
        end else begin
            tick_cnt <= tick ? '0 : tick_cnt + 1'b1;
        end
    end

    //============================================================
    // Flight control
    //============================================================
    always_ff @(posedge clock) begin
        if (reset) begin
            shot   <= '0;
            active <= 1'b0;
            hit    <= 1'b0;
        end else begin
            hit <= 1'b0;
            if (state == shooter_pkg::PLAY) begin
                if (!active) begin
                    if (key.fire) begin
                        shot.x <= ship.x + 10'd16;
                        shot.y <= ship.y;
                        active <= 1'b1;
                    end
                end else if (tick) begin
                    if (alive && overlap) begin
                        hit    <= 1'b1;
                        active <= 1'b0;
                    end else if (shot.x >= 10'(`SCREEN_X)) begin
                        active <= 1'b0;
                    end else begin
                        shot.x <= shot.x + 10'd1;
                    end
                end
            end
        end
    end
endmodule

// ==== design/game_control.sv ====
`include "shooter_macros.svh"

module game_control (
    input  logic                     clock,
    input  logic                     reset,
    input  shooter_pkg::wb_req_t     wb_req,
    output shooter_pkg::wb_rsp_t     wb_rsp,
    input  logic                     hit,
    input  logic                     alive,
    input  logic                     active,
    input  shooter_pkg::key_event_t  key,
    input  shooter_pkg::pos_t        ship,
    input  shooter_pkg::pos_t        alien,
    input  shooter_pkg::pos_t        shot,
    output shooter_pkg::game_state_e state
);
    logic       req;
    logic       start;
    logic       ack_q;
    logic [7:0] dat_q;
    logic [7:0] score;
    logic [7:0] status;

    // New request only when no ack is pending, so acks never run back to back
    assign req    = wb_req.cyc && wb_req.stb && !ack_q;
    assign start  = req && wb_req.we && (wb_req.adr == 3'(`REG_CTRL)) && wb_req.dat_w[0];
    assign status = {4'b0000, active, alive, state};

    //============================================================
    // Game FSM and score
    //============================================================
    always_ff @(posedge clock) begin
        if (reset) begin
            state <= shooter_pkg::MENU;
            score <= 8'd0;
        end else begin
            if (hit) begin
                score <= score + 8'd1;
            end
            case (state)
                shooter_pkg::MENU: if (start) state <= shooter_pkg::PLAY;
                shooter_pkg::PLAY: if (hit) state <= shooter_pkg::WON;
                shooter_pkg::WON:  state <= shooter_pkg::WON;
                default:           state <= shooter_pkg::MENU;
            endcase
        end
    end

    //============================================================
    // Wishbone slave
    //============================================================
    always_ff @(posedge clock) begin
        if (reset) begin
            ack_q <= 1'b0;
        end else begin
            ack_q <= req;
        end
    end

    // Positions go out in coarse units, x/4 and y/2
    always_ff @(posedge clock) begin
        if (req) begin
            case (wb_req.adr)
                3'(`REG_CTRL):      dat_q <= status;
                3'(`REG_SCANCODE):  dat_q <= key.scancode;
                3'(`REG_SCORE):     dat_q <= score;
                3'(`REG_SHIP_X):    dat_q <= ship.x[9:2];
                3'(`REG_SHIP_Y):    dat_q <= ship.y[8:1];
                3'(`REG_ALIEN_X):   dat_q <= alien.x[9:2];
                3'(`REG_ALIEN_Y):   dat_q <= alien.y[8:1];
                3'(`REG_MISSILE_X): dat_q <= shot.x[9:2];
                default:            dat_q <= 8'h00;
            endcase
        end
    end

    assign wb_rsp.ack   = ack_q;
    assign wb_rsp.dat_r = dat_q;
endmodule

// ==== design/shooter_top.sv ====
module shooter_top (
    input  logic                    clock,
    input  logic                    reset,
    input  shooter_pkg::ps2_lines_t ps2,
    input  shooter_pkg::wb_req_t    wb_req,
    output shooter_pkg::wb_rsp_t    wb_rsp
);
    shooter_pkg::key_event_t  key;
    shooter_pkg::game_state_e state;
    shooter_pkg::pos_t        ship;
    shooter_pkg::pos_t        alien;
    shooter_pkg::pos_t        shot;
    logic                     alive;
    logic                     active;
    logic                     hit;

    ps2_receiver u_ps2_receiver (
        .clock (clock),
        .reset (reset),
        .ps2   (ps2),
        .key   (key)
    );

    player_ship u_player_ship (
        .clock (clock),
        .reset (reset),
        .state (state),
        .key   (key),
        .ship  (ship)
    );

    alien_ship u_alien_ship (
        .clock (clock),
        .reset (reset),
        .state (state),
        .hit   (hit),
        .alien (alien),
        .alive (alive)
    );

    missile_tracker u_missile_tracker (
        .clock  (clock),
        .reset  (reset),
        .state  (state),
        .key    (key),
        .ship   (ship),
        .alien  (alien),
        .alive  (alive),
        .shot   (shot),
        .active (active),
        .hit    (hit)
    );

    game_control u_game_control (
        .clock  (clock),
        .reset  (reset),
        .wb_req (wb_req),
        .wb_rsp (wb_rsp),
        .hit    (hit),
        .alive  (alive),
        .active (active),
        .key    (key),
        .ship   (ship),
        .alien  (alien),
        .shot   (shot),
        .state  (state)
    );
endmodule

// ==== tb/clock_gen.sv ====
module clock_gen #(
    parameter int PERIOD       = 100,
    parameter int RESET_CYCLES = 2
) (
    output logic clock,
    output logic reset
);
    initial begin
        clock = 1'b0;
        forever #(PERIOD / 2) clock = ~clock;
    end

    // Reset released on a rising edge after the hold time
    initial begin
        reset = 1'b1;
        repeat (RESET_CYCLES) @(posedge clock);
        reset <= 1'b0;
    end
endmodule

// ==== tb/shooter_properties.sv ====
module shooter_properties (
    input logic                     clock,
    input logic                     reset,
    input shooter_pkg::wb_req_t     wb_req,
    input shooter_pkg::wb_rsp_t     wb_rsp,
    input shooter_pkg::game_state_e state,
    input logic                     hit,
    input logic                     active
);
    // Count of failed assertions
    int failures = 0;

    //============================================================
    // Wishbone handshake
    //============================================================
    ack_single_cycle: assert property (@(posedge clock) disable iff (reset)
        wb_rsp.ack |=> !wb_rsp.ack)
        else begin
            $error("ack asserted on two consecutive cycles");
            failures++;
        end

    ack_after_request: assert property (@(posedge clock) disable iff (reset)
        wb_rsp.ack |-> $past(wb_req.cyc && wb_req.stb))
        else begin
            $error("ack without a preceding cyc and stb");
            failures++;
        end

    //============================================================
    // Game rules
    //============================================================
    won_is_final: assert property (@(posedge clock) disable iff (reset)
        (state == shooter_pkg::WON) |=> (state == shooter_pkg::WON))
        else begin
            $error("state left WON without reset");
            failures++;
        end

    // A hit can only end a flight in progress
    hit_needs_flight: assert property (@(posedge clock) disable iff (reset)
        hit |-> $past(active))
        else begin
            $error("hit without an active missile");
            failures++;
        end
endmodule

bind shooter_top shooter_properties u_shooter_properties (
    .clock  (clock),
    .reset  (reset),
    .wb_req (wb_req),
    .wb_rsp (wb_rsp),
    .state  (state),
    .hit    (hit),
    .active (active)
);

// ==== tb/shooter_tb.sv ====
`include "shooter_macros.svh"

module shooter_tb;
    localparam int HALF_BIT    = 8;
    localparam int ACK_TIMEOUT = 16;
    localparam int POLL_GAP    = 32;
    localparam int POLL_LIMIT  = 2000;
    localparam int FAR_ROWS    = 40;
    localparam int NUM_MOVES   = 8;

    // One key frame with optional break prefix and its expected result
    typedef struct packed {
        logic       brk;
        logic [7:0] code;
        logic [9:0] exp_x;
        logic [8:0] exp_y;
        logic [7:0] exp_code;
    } move_row_t;

    logic                    clock;
    logic                    reset;
    shooter_pkg::ps2_lines_t ps2_lines;
    shooter_pkg::wb_req_t    bus_req;
    shooter_pkg::wb_rsp_t    bus_rsp;
    int                      checks   = 0;
    int                      errors   = 0;
    int                      timeouts = 0;

    // Ship starts at (320, 240) and y grows downward
    move_row_t moves [NUM_MOVES] = '{
        '{1'b0, `KEY_W, 10'd320, 9'd235, `KEY_W},
        '{1'b0, `KEY_D, 10'd325, 9'd235, `KEY_D},
        '{1'b0, `KEY_D, 10'd330, 9'd235, `KEY_D},
        '{1'b0, `KEY_S, 10'd330, 9'd240, `KEY_S},
        '{1'b0, `KEY_A, 10'd325, 9'd240, `KEY_A},
        '{1'b1, `KEY_D, 10'd325, 9'd240, `KEY_A},
        '{1'b0, `KEY_S, 10'd325, 9'd245, `KEY_S},
        '{1'b1, `KEY_W, 10'd325, 9'd245, `KEY_S}
    };

    logic [7:0] menu_keys [4] = '{`KEY_W, `KEY_A, `KEY_S, `KEY_D};

    clock_gen u_clock_gen (
        .clock (clock),
        .reset (reset)
    );

    shooter_top u_shooter_top (
        .clock  (clock),
        .reset  (reset),
        .ps2    (ps2_lines),
        .wb_req (bus_req),
        .wb_rsp (bus_rsp)
    );

    //============================================================
    // Reporting
    //============================================================
    task automatic finish_run();
        int assert_fails;
        assert_fails = u_shooter_top.u_shooter_properties.failures;
        $display("Checks: %0d, errors: %0d, assertion failures: %0d, timeouts: %0d",
                 checks, errors, assert_fails, timeouts);
        if (errors == 0 && assert_fails == 0 && timeouts == 0) begin
            $display("Simulation passed");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    endtask

    task automatic timed_out(input string what);
        timeouts++;
        $display("Timeout at time %0t: gave up waiting for %s", $time, what);
        finish_run();
    endtask

    task automatic check_value(input string what, input int got, input int exp);
        checks++;
        assert (got == exp) else begin
            errors++;
            $display("** Error at time %0t: %s is %0d, expected %0d", $time, what, got, exp);
        end
    endtask

    // Status byte has state in bits 1 to 0, alive in bit 2 and active in bit 3
    function automatic int expected_status(input shooter_pkg::game_state_e st,
                                           input logic alive, input logic active);
        return int'(st) + (alive ? 4 : 0) + (active ? 8 : 0);
    endfunction

    function automatic int abs_diff(input int a, input int b);
        return (a > b) ? a - b : b - a;
    endfunction

    //============================================================
    // PS/2 and Wishbone drivers
    //============================================================
    // Frame is start bit, data LSB first, odd parity and stop bit
    task automatic send_frame(input logic [7:0] code);
        logic [10:0] frame;
        frame = {1'b1, ~^code, code, 1'b0};
        @(posedge clock);
        for (int i = 0; i < 11; i++) begin
            ps2_lines.dat <= frame[i];
            repeat (HALF_BIT) @(posedge clock);
            ps2_lines.clk <= 1'b0;
            repeat (HALF_BIT) @(posedge clock);
            ps2_lines.clk <= 1'b1;
        end
        ps2_lines.dat <= 1'b1;
        repeat (HALF_BIT) @(posedge clock);
    endtask

    task automatic bus_access(input logic we, input logic [2:0] adr,
                              input logic [7:0] wdata, output logic [7:0] rdata);
        int waited;
        waited = 0;
        @(posedge clock);
        bus_req.cyc   <= 1'b1;
        bus_req.stb   <= 1'b1;
        bus_req.we    <= we;
        bus_req.adr   <= adr;
        bus_req.dat_w <= wdata;
        do begin
            @(negedge clock);
            waited++;
        end while (!bus_rsp.ack && waited < ACK_TIMEOUT);
        if (!bus_rsp.ack) begin
            timed_out("bus ack");
        end
        rdata = bus_rsp.dat_r;
        @(posedge clock);
        bus_req.cyc <= 1'b0;
        bus_req.stb <= 1'b0;
        bus_req.we  <= 1'b0;
    endtask

    task automatic read_reg(input logic [2:0] adr, output logic [7:0] data);
        bus_access(1'b0, adr, 8'h00, data);
    endtask

    // Polls a register until its masked value matches
    task automatic poll_register(input logic [2:0] adr, input logic [7:0] mask,
                                 input logic [7:0] value, input string what);
        logic [7:0] data;
        int         polls;
        polls = 0;
        read_reg(adr, data);
        while ((data & mask) != value && polls < POLL_LIMIT) begin
            repeat (POLL_GAP) @(posedge clock);
            read_reg(adr, data);
            polls++;
        end
        if ((data & mask) != value) begin
            timed_out(what);
        end
    endtask

    //============================================================
    // Test sequence
    //============================================================
    initial begin
        logic [7:0] rd;
        logic [7:0] shot_x0;
        int         ship_y;
        int         alien_y;
        int         presses;
        int         waited;
        logic       step_down;

        ps2_lines = '1;
        bus_req   = '0;
        waited    = 0;
        while (reset !== 1'b0 && waited < 20) begin
            @(posedge clock);
            waited++;
        end
        if (reset !== 1'b0) begin
            timed_out("reset release");
        end

        // Reset values
        read_reg(`REG_CTRL, rd);
        check_value("status after reset", rd, expected_status(shooter_pkg::MENU, 1'b1, 1'b0));
        read_reg(`REG_SCORE, rd);
        check_value("score after reset", rd, 0);
        read_reg(`REG_SHIP_X, rd);
        check_value("ship x after reset", rd, `SHIP_X0 / 4);
        read_reg(`REG_SHIP_Y, rd);
        check_value("ship y after reset", rd, `SHIP_Y0 / 2);
        read_reg(`REG_ALIEN_X, rd);
        check_value("alien x after reset", rd, `ALIEN_X0 / 4);

        // Keys in MENU only change the scancode
        foreach (menu_keys[i]) begin
            send_frame(menu_keys[i]);
            read_reg(`REG_SCANCODE, rd);
            check_value("scancode in menu", rd, menu_keys[i]);
            read_reg(`REG_SHIP_X, rd);
            check_value("ship x in menu", rd, `SHIP_X0 / 4);
            read_reg(`REG_SHIP_Y, rd);
            check_value("ship y in menu", rd, `SHIP_Y0 / 2);
        end

        bus_access(1'b1, `REG_CTRL, 8'h01, rd);
        read_reg(`REG_CTRL, rd);
        check_value("status in play", rd, expected_status(shooter_pkg::PLAY, 1'b1, 1'b0));

        foreach (moves[i]) begin
            if (moves[i].brk) begin
                send_frame(`KEY_BREAK);
            end
            send_frame(moves[i].code);
            read_reg(`REG_SHIP_X, rd);
            check_value("ship x after move", rd, moves[i].exp_x >> 2);
            read_reg(`REG_SHIP_Y, rd);
            check_value("ship y after move", rd, moves[i].exp_y >> 1);
            read_reg(`REG_SCANCODE, rd);
            check_value("scancode after move", rd, moves[i].exp_code);
        end
        ship_y = moves[NUM_MOVES - 1].exp_y;

        // Keep the ship well away from the alien row for a miss
        read_reg(`REG_ALIEN_Y, rd);
        alien_y = rd * 2;
        while (abs_diff(ship_y, alien_y) < FAR_ROWS) begin
            if (alien_y >= ship_y) begin
                send_frame(`KEY_W);
                ship_y = ship_y - `SHIP_STEP;
            end else begin
                send_frame(`KEY_S);
                ship_y = ship_y + `SHIP_STEP;
            end
        end
        read_reg(`REG_SHIP_Y, rd);
        check_value("ship y before miss", rd, ship_y / 2);
        send_frame(`KEY_FIRE);
        read_reg(`REG_CTRL, rd);
        check_value("status with missile", rd, expected_status(shooter_pkg::PLAY, 1'b1, 1'b1));
        read_reg(`REG_MISSILE_X, shot_x0);
        poll_register(`REG_MISSILE_X, 8'hFF, shot_x0 + 8'd1, "missile to advance");
        poll_register(`REG_CTRL, 8'h08, 8'h00, "missile to reach the edge");
        read_reg(`REG_MISSILE_X, rd);
        check_value("missile x at edge", rd, `SCREEN_X / 4);
        read_reg(`REG_SCORE, rd);
        check_value("score after miss", rd, 0);
        read_reg(`REG_CTRL, rd);
        check_value("status after miss", rd, expected_status(shooter_pkg::PLAY, 1'b1, 1'b0));

        // Line up with the alien row and fire for a hit
        read_reg(`REG_ALIEN_Y, rd);
        alien_y   = rd * 2;
        presses   = (abs_diff(ship_y, alien_y) + 2) / `SHIP_STEP;
        step_down = (alien_y > ship_y);
        repeat (presses) begin
            if (step_down) begin
                send_frame(`KEY_S);
                ship_y = ship_y + `SHIP_STEP;
            end else begin
                send_frame(`KEY_W);
                ship_y = ship_y - `SHIP_STEP;
            end
        end
        read_reg(`REG_SHIP_Y, rd);
        check_value("ship y before hit", rd, ship_y / 2);
        send_frame(`KEY_FIRE);
        poll_register(`REG_SCORE, 8'hFF, 8'h01, "score after hit");
        read_reg(`REG_CTRL, rd);
        check_value("status after hit", rd, expected_status(shooter_pkg::WON, 1'b0, 1'b0));

        // Firing again after the game ends scores nothing
        send_frame(`KEY_FIRE);
        read_reg(`REG_SCORE, rd);
        check_value("score after game end", rd, 1);
        read_reg(`REG_CTRL, rd);
        check_value("status after game end", rd,
                    expected_status(shooter_pkg::WON, 1'b0, 1'b0));

        finish_run();
    end
endmodule

// ==== verilog.f ====
+incdir+design
design/shooter_pkg.sv
design/bit_sync.sv
design/ps2_receiver.sv
design/player_ship.sv
design/alien_ship.sv
design/missile_tracker.sv
design/game_control.sv
design/shooter_top.sv
tb/clock_gen.sv
tb/shooter_properties.sv
tb/shooter_tb.sv

// ==== Bender.yml ====
package:
  name: shooter

sources:
  - include_dirs:
      - design
    files:
      - design/shooter_pkg.sv
      - design/bit_sync.sv
      - design/ps2_receiver.sv
      - design/player_ship.sv
      - design/alien_ship.sv
      - design/missile_tracker.sv
      - design/game_control.sv
      - design/shooter_top.sv
  - target: test
    include_dirs:
      - design
    files:
      - tb/clock_gen.sv
      - tb/shooter_properties.sv
      - tb/shooter_tb.sv
